//--- common/conv_pkg.sv
package conv_pkg;

	//////////////////////////////
	// Image and kernel sizes
	//////////////////////////////

	localparam int IMAGE_WIDTH    = 8;
	localparam int IMAGE_HEIGHT   = 8;
	localparam int CHANNEL_NUM_IN = 2;
	localparam int KERNEL         = 3;

	// Signed data and accumulator widths
	localparam int DATA_WIDTH = 16;
	localparam int ACC_WIDTH  = 40;

	localparam int WINDOW_SIZE = KERNEL * KERNEL;
	// Valid positions only, no padding
	localparam int OUT_SIZE    = (IMAGE_WIDTH - KERNEL + 1) * (IMAGE_HEIGHT - KERNEL + 1);
	localparam int WEIGHT_NUM  = CHANNEL_NUM_IN * WINDOW_SIZE;
	localparam int FIFO_DEPTH  = 64;

	// Counter and pointer widths
	localparam int CHANNEL_WIDTH    = (CHANNEL_NUM_IN > 1) ? $clog2(CHANNEL_NUM_IN) : 1;
	localparam int COL_WIDTH        = $clog2(IMAGE_WIDTH);
	localparam int ROW_WIDTH        = $clog2(IMAGE_HEIGHT);
	localparam int WEIGHT_IDX_WIDTH = $clog2(WEIGHT_NUM);
	localparam int OUT_ADDR_WIDTH   = $clog2(OUT_SIZE);
	localparam int FIFO_ADDR_WIDTH  = $clog2(FIFO_DEPTH);

	// Clamp limits of the result range
	localparam logic signed [ACC_WIDTH-1:0] SAT_MAX = (2 ** (DATA_WIDTH - 1)) - 1;
	localparam logic signed [ACC_WIDTH-1:0] SAT_MIN = -(2 ** (DATA_WIDTH - 1));

	//////////////////////////////
	// Stream structs
	//////////////////////////////

	typedef struct packed {
		logic                         valid;
		logic signed [DATA_WIDTH-1:0] data;
	} pixel_t;

	// Pixel 0 is top left, pixel 8 bottom right
	typedef struct packed {
		logic                                    valid;
		logic [CHANNEL_WIDTH-1:0]                channel;
		logic [WINDOW_SIZE-1:0][DATA_WIDTH-1:0] pixels;
	} window_t;

	typedef struct packed {
		logic                        valid;
		logic [CHANNEL_WIDTH-1:0]    channel;
		logic signed [ACC_WIDTH-1:0] sum;
	} psum_t;

	// Clamp an accumulator value into the signed data range
	function automatic logic signed [DATA_WIDTH-1:0] saturate(
		input logic signed [ACC_WIDTH-1:0] value
	);
		if (value > SAT_MAX) begin
			return SAT_MAX[DATA_WIDTH-1:0];
		end else if (value < SAT_MIN) begin
			return SAT_MIN[DATA_WIDTH-1:0];
		end
		return value[DATA_WIDTH-1:0];
	endfunction

endpackage

//--- design/conv_window_gen.sv
`timescale 1ns/1ns

module conv_window_gen (
	input  logic              clk,
	input  logic              reset,
	input  conv_pkg::pixel_t  pixel_in,
	output conv_pkg::window_t window_out
);

	// Previous two rows of the current plane
	logic signed [conv_pkg::DATA_WIDTH-1:0] line_buf_1 [conv_pkg::IMAGE_WIDTH];
	logic signed [conv_pkg::DATA_WIDTH-1:0] line_buf_2 [conv_pkg::IMAGE_WIDTH];

	logic [conv_pkg::COL_WIDTH-1:0]     col;
	logic [conv_pkg::ROW_WIDTH-1:0]     row;
	logic [conv_pkg::CHANNEL_WIDTH-1:0] channel;

	logic [conv_pkg::WINDOW_SIZE-1:0][conv_pkg::DATA_WIDTH-1:0] win;
	logic                                                       win_valid;
	logic [conv_pkg::CHANNEL_WIDTH-1:0]                         win_channel;

	//////////////////////////////
	// Raster position counters
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			col       <= '0;
			row       <= '0;
			channel   <= '0;
			win_valid <= 1'b0;
		end else begin
			// Window fully inside the plane
			win_valid <= pixel_in.valid && (row >= conv_pkg::ROW_WIDTH'(conv_pkg::KERNEL - 1))
				&& (col >= conv_pkg::COL_WIDTH'(conv_pkg::KERNEL - 1));
			if (pixel_in.valid) begin
				if (col == conv_pkg::COL_WIDTH'(conv_pkg::IMAGE_WIDTH - 1)) begin
					col <= '0;
					if (row == conv_pkg::ROW_WIDTH'(conv_pkg::IMAGE_HEIGHT - 1)) begin
						row <= '0;
						// Next plane, or next image after the last channel
						if (channel == conv_pkg::CHANNEL_WIDTH'(conv_pkg::CHANNEL_NUM_IN - 1)) begin
							channel <= '0;
						end else begin
							channel <= channel + 1'b1;
						end
					end else begin
						row <= row + 1'b1;
					end
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

	// Line buffers and the 3x3 shift window
	always_ff @(posedge clk) begin
		if (pixel_in.valid) begin
			line_buf_2[col] <= line_buf_1[col];
			line_buf_1[col] <= pixel_in.data;
			for (int r = 0; r < conv_pkg::KERNEL; r++) begin
				win[r*conv_pkg::KERNEL]     <= win[r*conv_pkg::KERNEL + 1];
				win[r*conv_pkg::KERNEL + 1] <= win[r*conv_pkg::KERNEL + 2];
			end
			// New right column, oldest row on top
			win[2] <= line_buf_2[col];
			win[5] <= line_buf_1[col];
			win[8] <= pixel_in.data;
			win_channel <= channel;
		end
	end

	assign window_out = '{valid: win_valid, channel: win_channel, pixels: win};

endmodule

//--- conv_mac/conv_mac.sv
`timescale 1ns/1ns

module conv_mac (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic                                   weight_valid,
	input  logic signed [conv_pkg::DATA_WIDTH-1:0] weight_data,
	input  conv_pkg::window_t                      window_in,
	output conv_pkg::psum_t                        psum_out
);

	//////////////////////////////
	// Weight store
	//////////////////////////////

	// Ordered by channel, then row, then column
	logic signed [conv_pkg::DATA_WIDTH-1:0] weights [conv_pkg::WEIGHT_NUM];
	logic [conv_pkg::WEIGHT_IDX_WIDTH-1:0]  weight_idx;

	always_ff @(posedge clk) begin
		if (reset) begin
			weight_idx <= '0;
		end else if (weight_valid) begin
			if (weight_idx == conv_pkg::WEIGHT_IDX_WIDTH'(conv_pkg::WEIGHT_NUM - 1)) begin
				weight_idx <= '0;
			end else begin
				weight_idx <= weight_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (weight_valid) begin
			weights[weight_idx] <= weight_data;
		end
	end

	//////////////////////////////
	// Stage one, products
	//////////////////////////////

	logic signed [conv_pkg::ACC_WIDTH-1:0] products [conv_pkg::WINDOW_SIZE];
	logic                                  prod_valid;
	logic [conv_pkg::CHANNEL_WIDTH-1:0]    prod_channel;

	always_ff @(posedge clk) begin
		if (window_in.valid) begin
			// Channel picks its block of nine weights
			for (int k = 0; k < conv_pkg::WINDOW_SIZE; k++) begin
				products[k] <= $signed(window_in.pixels[k])
					* weights[int'(window_in.channel) * conv_pkg::WINDOW_SIZE + k];
			end
			prod_channel <= window_in.channel;
		end
	end

	//////////////////////////////
	// Stage two, adder tree
	//////////////////////////////

	logic signed [conv_pkg::ACC_WIDTH-1:0] tree_sum;
	logic signed [conv_pkg::ACC_WIDTH-1:0] sum_reg;
	logic                                  sum_valid;
	logic [conv_pkg::CHANNEL_WIDTH-1:0]    sum_channel;

	always_comb begin
		tree_sum = '0;
		for (int k = 0; k < conv_pkg::WINDOW_SIZE; k++) begin
			tree_sum = tree_sum + products[k];
		end
	end

	always_ff @(posedge clk) begin
		sum_reg     <= tree_sum;
		sum_channel <= prod_channel;
	end

	// Valid bits walk alongside the two data stages
	always_ff @(posedge clk) begin
		if (reset) begin
			prod_valid <= 1'b0;
			sum_valid  <= 1'b0;
		end else begin
			prod_valid <= window_in.valid;
			sum_valid  <= prod_valid;
		end
	end

	assign psum_out = '{valid: sum_valid, channel: sum_channel, sum: sum_reg};

endmodule

//--- design/conv_channel_adder.sv
`timescale 1ns/1ns

module conv_channel_adder (
	input  logic                                   clk,
	input  logic                                   reset,
	input  conv_pkg::psum_t                        psum_in,
	output logic                                   result_valid,
	output logic signed [conv_pkg::DATA_WIDTH-1:0] result_data
);

	// One partial sum per output position
	logic signed [conv_pkg::ACC_WIDTH-1:0] psum_mem [conv_pkg::OUT_SIZE];
	logic [conv_pkg::OUT_ADDR_WIDTH-1:0]   addr;

	logic                                  is_first;
	logic                                  is_last;
	logic signed [conv_pkg::ACC_WIDTH-1:0] total;

	assign is_first = (psum_in.channel == '0);
	assign is_last  = (psum_in.channel
		== conv_pkg::CHANNEL_WIDTH'(conv_pkg::CHANNEL_NUM_IN - 1));

	// First channel starts from zero, later ones accumulate
	assign total = is_first ? psum_in.sum : psum_mem[addr] + psum_in.sum;

	//////////////////////////////
	// Position counter
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			addr         <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= psum_in.valid && is_last;
			if (psum_in.valid) begin
				// Wraps at the end of every plane
				if (addr == conv_pkg::OUT_ADDR_WIDTH'(conv_pkg::OUT_SIZE - 1)) begin
					addr <= '0;
				end else begin
					addr <= addr + 1'b1;
				end
			end
		end
	end

	// Store running sums, emit on the last channel
	always_ff @(posedge clk) begin
		if (psum_in.valid) begin
			if (is_last) begin
				result_data <= conv_pkg::saturate(total);
			end else begin
				psum_mem[addr] <= total;
			end
		end
	end

endmodule

//--- design/conv_out_fifo.sv
`timescale 1ns/1ns

module conv_out_fifo (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic                                   wr_valid,
	input  logic signed [conv_pkg::DATA_WIDTH-1:0] wr_data,
	output logic                                   out_valid,
	output logic signed [conv_pkg::DATA_WIDTH-1:0] out_data,
	input  logic                                   out_ready,
	output logic                                   room
);

	logic signed [conv_pkg::DATA_WIDTH-1:0] mem [conv_pkg::FIFO_DEPTH];
	logic [conv_pkg::FIFO_ADDR_WIDTH-1:0]   wr_ptr;
	logic [conv_pkg::FIFO_ADDR_WIDTH-1:0]   rd_ptr;
	logic [conv_pkg::FIFO_ADDR_WIDTH:0]     count;

	logic push;
	logic pop;

	assign push = wr_valid && (count != (conv_pkg::FIFO_ADDR_WIDTH + 1)'(conv_pkg::FIFO_DEPTH));
	assign pop  = out_valid && out_ready;

	// Head word is visible without a read request
	assign out_valid = (count != '0);
	assign out_data  = mem[rd_ptr];

	// Enough space left for one whole image
	assign room = (count <= (conv_pkg::FIFO_ADDR_WIDTH + 1)'(conv_pkg::FIFO_DEPTH - conv_pkg::OUT_SIZE));

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1;
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- design/conv_layer_top.sv
`timescale 1ns/1ns

module conv_layer_top (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic                                   pixel_valid,
	input  logic signed [conv_pkg::DATA_WIDTH-1:0] pixel_data,
	input  logic                                   weight_valid,
	input  logic signed [conv_pkg::DATA_WIDTH-1:0] weight_data,
	output logic                                   in_ready,
	output logic                                   out_valid,
	output logic signed [conv_pkg::DATA_WIDTH-1:0] out_data,
	input  logic                                   out_ready
);

	conv_pkg::pixel_t                       pixel_s;
	conv_pkg::window_t                      window_s;
	conv_pkg::psum_t                        psum_s;
	logic                                   result_valid;
	logic signed [conv_pkg::DATA_WIDTH-1:0] result_data;

	assign pixel_s = '{valid: pixel_valid, data: pixel_data};

	// Pixel stream to 3x3 windows
	conv_window_gen conv_window_gen_inst (
		.clk       (clk     ),
		.reset     (reset   ),
		.pixel_in  (pixel_s ),
		.window_out(window_s)
	);

	conv_mac conv_mac_inst (
		.clk         (clk         ),
		.reset       (reset       ),
		.weight_valid(weight_valid),
		.weight_data (weight_data ),
		.window_in   (window_s    ),
		.psum_out    (psum_s      )
	);

	// Sum over input channels
	conv_channel_adder conv_channel_adder_inst (
		.clk         (clk         ),
		.reset       (reset       ),
		.psum_in     (psum_s      ),
		.result_valid(result_valid),
		.result_data (result_data )
	);

	conv_out_fifo conv_out_fifo_inst (
		.clk      (clk         ),
		.reset    (reset       ),
		.wr_valid (result_valid),
		.wr_data  (result_data ),
		.out_valid(out_valid   ),
		.out_data (out_data    ),
		.out_ready(out_ready   ),
		.room     (in_ready    )
	);

endmodule

//--- bench/conv_layer_sva.sv
`timescale 1ns/1ns

module conv_layer_sva (
	input logic                                   clk,
	input logic                                   reset,
	input logic                                   in_ready,
	input logic                                   out_valid,
	input logic signed [conv_pkg::DATA_WIDTH-1:0] out_data,
	input logic                                   out_ready
);

	int failures = 0;

	//////////////////////////////
	// Result stream
	//////////////////////////////

	// FIFO empty in reset and on the first cycle after it
	reset_clears_output: assert property (@(posedge clk) reset |=> !out_valid)
	else begin
		$error("out_valid high during reset or on the cycle after it");
		failures++;
	end

	hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_data))
	else begin
		$error("out_data changed while the consumer stalled");
		failures++;
	end

	// Empty FIFO always has room for an image
	room_when_empty: assert property (@(posedge clk) disable iff (reset) !out_valid |-> in_ready)
	else begin
		$error("in_ready low with an empty FIFO");
		failures++;
	end

endmodule

//--- bench/conv_layer_tb.sv
`timescale 1ns/1ns

module conv_layer_tb;

	localparam int TIMEOUT = 4000;
	localparam int WIN     = conv_pkg::KERNEL * conv_pkg::KERNEL;
	localparam int PLANE   = conv_pkg::IMAGE_WIDTH * conv_pkg::IMAGE_HEIGHT;
	localparam int IMAGE   = PLANE * conv_pkg::CHANNEL_NUM_IN;

	logic                                   clk          = 1'b0;
	logic                                   reset        = 1'b1;
	logic                                   pixel_valid  = 1'b0;
	logic signed [conv_pkg::DATA_WIDTH-1:0] pixel_data   = '0;
	logic                                   weight_valid = 1'b0;
	logic signed [conv_pkg::DATA_WIDTH-1:0] weight_data  = '0;
	logic                                   out_ready    = 1'b0;
	logic                                   in_ready;
	logic                                   out_valid;
	logic signed [conv_pkg::DATA_WIDTH-1:0] out_data;

	logic ready_level  = 1'b1;
	logic ready_random = 1'b0;
	int   pixels [conv_pkg::CHANNEL_NUM_IN][conv_pkg::IMAGE_HEIGHT][conv_pkg::IMAGE_WIDTH];
	int   weights [conv_pkg::WEIGHT_NUM];
	int   expected_q [$];
	int   error_count  = 0;
	int   check_count  = 0;
	int   tests_passed = 0;
	int   tests_failed = 0;
	int   test_errors  = 0;

	conv_layer_top conv_layer_top_inst (
		.clk         (clk         ),
		.reset       (reset       ),
		.pixel_valid (pixel_valid ),
		.pixel_data  (pixel_data  ),
		.weight_valid(weight_valid),
		.weight_data (weight_data ),
		.in_ready    (in_ready    ),
		.out_valid   (out_valid   ),
		.out_data    (out_data    ),
		.out_ready   (out_ready   )
	);

	bind conv_layer_top conv_layer_sva conv_layer_sva_inst (
		.clk      (clk      ),
		.reset    (reset    ),
		.in_ready (in_ready ),
		.out_valid(out_valid),
		.out_data (out_data ),
		.out_ready(out_ready)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		out_ready <= ready_random ? 1'($urandom_range(1)) : ready_level;
	end

	// Word is taken on the next rising edge
	always @(negedge clk) begin
		if (!reset && out_valid && out_ready) begin
			assert (expected_q.size() > 0) else begin
				$display("Output word %0d arrived with no result expected", out_data);
				error_count++;
			end
			if (expected_q.size() > 0) begin
				check_count++;
				assert (int'(out_data) == expected_q[0]) else begin
					$display("CHECK FAILED at %0t: result %0d, expected %0d",
						$time, out_data, expected_q[0]);
					error_count++;
				end
				void'(expected_q.pop_front());
			end
		end
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic int limit_to_data(input longint value);
		longint top;
		top = (longint'(1) <<< (conv_pkg::DATA_WIDTH - 1)) - 1;
		if (value > top) return int'(top);
		if (value < -top - 1) return int'(-top - 1);
		return int'(value);
	endfunction

	// Valid correlation per plane, summed over planes
	task automatic queue_expected();
		longint sum;
		for (int r = 0; r <= conv_pkg::IMAGE_HEIGHT - conv_pkg::KERNEL; r++) begin
			for (int c = 0; c <= conv_pkg::IMAGE_WIDTH - conv_pkg::KERNEL; c++) begin
				sum = 0;
				for (int ch = 0; ch < conv_pkg::CHANNEL_NUM_IN; ch++) begin
					for (int k = 0; k < WIN; k++) begin
						sum += longint'(pixels[ch][r + k / conv_pkg::KERNEL][c + k % conv_pkg::KERNEL])
							* longint'(weights[ch * WIN + k]);
					end
				end
				expected_q.push_back(limit_to_data(sum));
			end
		end
	endtask

	function automatic int total_errors();
		return error_count + conv_layer_top_inst.conv_layer_sva_inst.failures;
	endfunction

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	task automatic fill_image(input int pix_lo, input int pix_hi, input int wt_lo, input int wt_hi);
		foreach (pixels[ch, r, c]) begin
			pixels[ch][r][c] = pix_lo + int'($urandom_range(pix_hi - pix_lo));
		end
		foreach (weights[i]) begin
			weights[i] = wt_lo + int'($urandom_range(wt_hi - wt_lo));
		end
	endtask

	task automatic wait_in_ready(input logic level);
		int n;
		n = 0;
		@(negedge clk);
		while (in_ready !== level && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		assert (in_ready === level) else begin
			$display("Timed out waiting for in_ready to become %0b", level);
			error_count++;
		end
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while (expected_q.size() > 0 && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		assert (expected_q.size() == 0) else begin
			$display("Timed out with %0d results never delivered", expected_q.size());
			error_count++;
			expected_q.delete();
		end
	endtask

	// Weights first, then planes in raster order
	task automatic send_image(input int pixel_num, input bit check);
		wait_in_ready(1'b1);
		for (int i = 0; i < conv_pkg::WEIGHT_NUM; i++) begin
			@(posedge clk);
			weight_valid <= 1'b1;
			weight_data  <= conv_pkg::DATA_WIDTH'(weights[i]);
		end
		@(posedge clk);
		weight_valid <= 1'b0;
		if (check) queue_expected();
		for (int i = 0; i < pixel_num; i++) begin
			@(posedge clk);
			pixel_valid <= 1'b1;
			pixel_data  <= conv_pkg::DATA_WIDTH'(pixels[i / PLANE][(i % PLANE) / conv_pkg::IMAGE_WIDTH]
				[i % conv_pkg::IMAGE_WIDTH]);
		end
		@(posedge clk);
		pixel_valid <= 1'b0;
	endtask

	task automatic apply_reset();
		@(posedge clk);
		reset <= 1'b1;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic finish_test(input string name);
		if (total_errors() == test_errors) begin
			tests_passed++;
			$display("Test %s passed", name);
		end else begin
			tests_failed++;
			$display("Test %s failed with %0d errors", name, total_errors() - test_errors);
		end
		test_errors = total_errors();
	endtask

	initial begin
		void'($urandom(67));
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		// Center weights only
		fill_image(-100, 100, 0, 0);
		for (int ch = 0; ch < conv_pkg::CHANNEL_NUM_IN; ch++) begin
			weights[ch * WIN + WIN / 2] = 1;
		end
		send_image(IMAGE, 1'b1);
		wait_drained();
		finish_test("identity kernels");

		fill_image(-50, 50, -8, 8);
		send_image(IMAGE, 1'b1);
		fill_image(-50, 50, -8, 8);
		send_image(IMAGE, 1'b1);
		wait_drained();
		finish_test("random weights and pixels");

		// One image clamps high, the other low
		fill_image(30000, 32767, 30000, 32767);
		send_image(IMAGE, 1'b1);
		fill_image(-32768, -30000, 30000, 32767);
		send_image(IMAGE, 1'b1);
		wait_drained();
		finish_test("saturation");

		ready_level <= 1'b0;
		fill_image(-50, 50, -8, 8);
		send_image(IMAGE, 1'b1);
		wait_in_ready(1'b0);
		ready_random <= 1'b1;
		repeat (2) begin
			fill_image(-50, 50, -8, 8);
			send_image(IMAGE, 1'b1);
		end
		wait_drained();
		ready_random <= 1'b0;
		ready_level  <= 1'b1;
		finish_test("back-pressure");

		fill_image(-50, 50, -8, 8);
		send_image(IMAGE, 1'b1);
		fill_image(-50, 50, -100, 100);
		send_image(IMAGE, 1'b1);
		wait_drained();
		finish_test("weight reload");

		// Stop inside the last plane with results queued
		ready_level <= 1'b0;
		fill_image(-50, 50, -8, 8);
		send_image(PLANE + 5 * conv_pkg::IMAGE_WIDTH, 1'b0);
		repeat (6) @(negedge clk);
		assert (out_valid) else begin
			$display("CHECK FAILED at %0t: out_valid low with results pending before the reset",
				$time);
			error_count++;
		end
		apply_reset();
		@(negedge clk);
		assert (!out_valid) else begin
			$display("CHECK FAILED at %0t: out_valid still high after the reset", $time);
			error_count++;
		end
		ready_level <= 1'b1;
		fill_image(-50, 50, -8, 8);
		send_image(IMAGE, 1'b1);
		wait_drained();
		finish_test("reset mid-image");

		$display("%0d tests passed, %0d failed, %0d words checked, %0d errors",
			tests_passed, tests_failed, check_count, total_errors());
		if (total_errors() == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

//--- conv_layer_top.f
common/conv_pkg.sv
design/conv_window_gen.sv
conv_mac/conv_mac.sv
design/conv_channel_adder.sv
design/conv_out_fifo.sv
design/conv_layer_top.sv
bench/conv_layer_sva.sv
bench/conv_layer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --assert -Wno-fatal --top-module conv_layer_tb \
	-f conv_layer_top.f -o conv_layer_sim > build.log 2>&1 \
	&& ./obj_dir/conv_layer_sim +verilator+error+limit+100 > sim.log 2>&1
grep -qx "STATUS: PASS" sim.log && echo "Simulation passed" && exit 0 \
	|| { echo "Simulation failed, see build.log and sim.log"; exit 1; }
